//--- tb/uart_rx_vectors.txt
# name bit8 parity_en odd_n_even data(hex) inject stop read_after
#   exp_byte(hex) exp_full exp_overflow exp_parity_err exp_framing_error  (inject 1 = bad parity, 2 = glitch)
b8_plain    1 0 0 a5 0 1 1 a5 1 0 0 0
b7_plain    0 0 0 d3 0 1 1 53 1 0 0 0
even_ok     1 1 0 3c 0 1 1 3c 1 0 0 0
odd_ok      1 1 1 71 0 1 1 71 1 0 0 0
odd_ok7     0 1 1 4e 0 1 1 4e 1 0 0 0
even_bad    1 1 0 5a 1 1 1 5a 1 0 1 0
odd_bad7    0 1 1 e9 1 1 1 69 1 0 1 0
stop_low    1 0 0 81 0 0 1 81 1 0 0 1
ovf_first   1 0 0 12 0 1 0 12 1 0 0 0
ovf_second  1 0 0 34 0 1 1 12 1 1 0 0
glitch_b8   1 0 0 c6 2 1 1 c6 1 0 0 0
glitch_b7   0 1 0 2b 2 1 1 2b 1 0 0 0

//--- flist.f
hdl/uart_rx_pkg.sv
hdl/rx_majority_filter.sv
hdl/rx_bit_timer.sv
hdl/rx_frame_fsm.sv
hdl/rx_status_regs.sv
hdl/uart_rx.sv
tb/uart_rx_tb.sv

//--- Bender.yml
package:
  name: uart_rx

sources:
  - files:
      - hdl/uart_rx_pkg.sv
      - hdl/rx_majority_filter.sv
      - hdl/rx_bit_timer.sv
      - hdl/rx_frame_fsm.sv
      - hdl/rx_status_regs.sv
      - hdl/uart_rx.sv
  - target: test
    files:
      - tb/uart_rx_tb.sv

//--- tb/uart_rx_tb.sv
// uart receiver testbench
`timescale 1ns/1ps
`default_nettype none

module uart_rx_tb;

  logic       clk = 1'b0;
  logic       aresetn;
  logic       baud_tick = 1'b0;
  logic       rx;
  logic       bit8;
  logic       parity_en;
  logic       odd_n_even;
  logic       read_rx_byte;
  logic       clear_parity;
  logic       clear_framing_error;
  logic [7:0] rx_byte;
  logic       receive_full;
  logic       overflow;
  logic       parity_err;
  logic       framing_error;

  integer seed = 32'h7dbc78a6;
  int     errors = 0;
  int     tests = 0;
  int     failed_tests = 0;

  // expected state of the holding register and flags
  logic [7:0] ref_byte = 8'h00;
  logic       ref_full = 1'b0;
  logic       ref_ovf = 1'b0;
  logic       ref_par = 1'b0;
  logic       ref_frm = 1'b0;

  uart_rx dut_i (
    .clk                 (clk),
    .aresetn             (aresetn),
    .baud_tick           (baud_tick),
    .rx                  (rx),
    .bit8                (bit8),
    .parity_en           (parity_en),
    .odd_n_even          (odd_n_even),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

  always #4 clk = ~clk; // 8 ns period

  always @(posedge clk)
  begin
    baud_tick <= aresetn ? ~baud_tick : 1'b0; // 16x strobe on every second clk
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: rx_byte expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input string flag, input logic expected,
                            input logic actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: %s expected %b, actual %b", name, flag, expected, actual);
      errors++;
    end
  endtask

  // ----------------------------------------
  // serial line driver
  // ----------------------------------------
  task automatic send_bit(input logic level, input bit glitch, input int offset);
    for (int i = 0; i < 32; i++)
    begin
      if (glitch && i >= offset && i < offset + 2)
        rx <= ~level; // one baud_tick wide
      else
        rx <= level;
      @(posedge clk);
    end
  endtask

  task automatic send_frame(input logic [7:0] data, input logic b8, input logic pen,
                            input logic odd, input int inject, input logic stop);
    int   nbits;
    int   glitch_bit;
    int   offset;
    logic par;
    nbits = b8 ? 8 : 7;
    par = ^(b8 ? data : {1'b0, data[6:0]}) ^ odd; // even parity unless odd is set
    if (inject == 1)
      par = ~par;
    glitch_bit = (inject == 2) ? $unsigned($random(seed)) % nbits : -1;
    offset = 10 + $unsigned($random(seed)) % 12; // middle part of the bit
    send_bit(1'b0, 1'b0, 0);
    for (int i = 0; i < nbits; i++)
      send_bit(data[i], i == glitch_bit, offset);
    if (pen)
      send_bit(par, 1'b0, 0);
    send_bit(stop, 1'b0, 0);
    send_bit(1'b1, 1'b0, 0); // two idle bit times
    send_bit(1'b1, 1'b0, 0);
  endtask

  // one clk pulse on a single strobe, 0 read, 1 parity clear, 2 framing clear
  task automatic pulse_strobe(input int which);
    @(posedge clk);
    case (which)
      0:       read_rx_byte        <= 1'b1;
      1:       clear_parity        <= 1'b1;
      default: clear_framing_error <= 1'b1;
    endcase
    @(posedge clk);
    read_rx_byte        <= 1'b0;
    clear_parity        <= 1'b0;
    clear_framing_error <= 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_full(input string name);
    int cycles;
    cycles = 0;
    while (!receive_full && cycles < 400)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!receive_full)
    begin
      $display("byte never arrived in test %s", name);
      errors++;
    end
  endtask

  // ----------------------------------------
  // vector loop
  // ----------------------------------------
  initial
  begin
    int         fd;
    string      line;
    string      name;
    int         b8;
    int         pen;
    int         odd;
    int         inject;
    int         stop;
    int         rd;
    int         e_full;
    int         e_ovf;
    int         e_par;
    int         e_frm;
    int         errors_before;
    logic [7:0] data;
    logic [7:0] e_byte;

    aresetn             <= 1'b0;
    rx                  <= 1'b1;
    bit8                <= 1'b1;
    parity_en           <= 1'b0;
    odd_n_even          <= 1'b0;
    read_rx_byte        <= 1'b0;
    clear_parity        <= 1'b0;
    clear_framing_error <= 1'b0;
    repeat (4) @(posedge clk);
    aresetn <= 1'b1;
    repeat (4) @(posedge clk);

    fd = $fopen("tb/uart_rx_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("the vector file could not be opened");
      errors++;
    end

    while (fd != 0 && $fgets(line, fd) > 0)
    begin
      if (line.len() < 2 || line[0] == "#")
        continue;
      if ($sscanf(line, "%s %d %d %d %h %d %d %d %h %d %d %d %d", name, b8, pen, odd, data,
                  inject, stop, rd, e_byte, e_full, e_ovf, e_par, e_frm) != 13)
      begin
        $display("a vector line could not be parsed");
        errors++;
        continue;
      end
      tests++;
      errors_before = errors;
      bit8       <= b8[0];
      parity_en  <= pen[0];
      odd_n_even <= odd[0];
      @(posedge clk);
      send_frame(data, b8[0], pen[0], odd[0], inject, stop[0]);

      // expected result from the receive rules
      if (ref_full)
        ref_ovf = 1'b1;
      else
      begin
        ref_byte = b8[0] ? data : {1'b0, data[6:0]};
        ref_full = 1'b1;
      end
      if (pen != 0 && inject == 1)
        ref_par = 1'b1;
      if (stop == 0)
        ref_frm = 1'b1;
      if ({ref_byte, ref_full, ref_ovf, ref_par, ref_frm} !==
          {e_byte, e_full[0], e_ovf[0], e_par[0], e_frm[0]})
      begin
        $display("vector file disagrees with the receive rules in test %s", name);
        errors++;
      end

      wait_full(name);
      @(negedge clk);
      check_byte(name, e_byte, rx_byte);
      check_flag(name, "receive_full", e_full[0], receive_full);
      check_flag(name, "overflow", e_ovf[0], overflow);
      check_flag(name, "parity_err", e_par[0], parity_err);
      check_flag(name, "framing_error", e_frm[0], framing_error);

      if (rd != 0)
      begin
        // each strobe alone, the other flags must hold
        pulse_strobe(0);
        ref_full = 1'b0;
        ref_ovf  = 1'b0;
        check_flag(name, "receive_full after read", 1'b0, receive_full);
        check_flag(name, "overflow after read", 1'b0, overflow);
        check_flag(name, "parity_err after read", e_par[0], parity_err);
        check_flag(name, "framing_error after read", e_frm[0], framing_error);

        pulse_strobe(1);
        ref_par = 1'b0;
        check_flag(name, "parity_err after clear", 1'b0, parity_err);
        check_flag(name, "framing_error after parity clear", e_frm[0], framing_error);

        pulse_strobe(2);
        ref_frm = 1'b0;
        check_flag(name, "framing_error after clear", 1'b0, framing_error);
      end

      if (errors == errors_before)
        $display("[PASS] %s", name);
      else
      begin
        $display("[FAIL] %s", name);
        failed_tests++;
      end
    end

    if (fd != 0)
      $fclose(fd);
    if (tests == 0)
    begin
      $display("no vectors were read");
      errors++;
    end
    $display("tests %0d, failing tests %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
// asynchronous serial receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire        clk,
  input  wire        aresetn,
  input  wire        baud_tick,           // 16x bit rate strobe
  input  wire        rx,
  input  wire        bit8,
  input  wire        parity_en,
  input  wire        odd_n_even,
  input  wire        read_rx_byte,
  input  wire        clear_parity,
  input  wire        clear_framing_error,
  output logic [7:0] rx_byte,
  output logic       receive_full,
  output logic       overflow,
  output logic       parity_err,
  output logic       framing_error
);

  logic rx_filtered;
  logic in_idle;
  logic in_wait;
  logic start_seen;
  logic sample_now;
  logic stop_check;
  logic wait_done;
  logic frame_done;
  logic stop_bad;

  uart_rx_pkg::frame_word_u frame_word;

  // ----------------------------------------
  // receive path
  // ----------------------------------------
  rx_majority_filter filter_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .rx_filtered (rx_filtered)
  );

  rx_bit_timer timer_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx_filtered (rx_filtered),
    .in_idle     (in_idle),
    .in_wait     (in_wait),
    .start_seen  (start_seen),
    .sample_now  (sample_now),
    .stop_check  (stop_check),
    .wait_done   (wait_done)
  );

  rx_frame_fsm fsm_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .rx_filtered (rx_filtered),
    .start_seen  (start_seen),
    .sample_now  (sample_now),
    .stop_check  (stop_check),
    .wait_done   (wait_done),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .in_idle     (in_idle),
    .in_wait     (in_wait),
    .frame_done  (frame_done),
    .frame_word  (frame_word),
    .stop_bad    (stop_bad)
  );

  rx_status_regs status_i (
    .clk                 (clk),
    .aresetn             (aresetn),
    .frame_done          (frame_done),
    .frame_word          (frame_word),
    .stop_bad            (stop_bad),
    .bit8                (bit8),
    .parity_en           (parity_en),
    .odd_n_even          (odd_n_even),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

endmodule

`default_nettype wire

//--- hdl/rx_status_regs.sv
// receive byte and status flags
`timescale 1ns/1ps
`default_nettype none

module rx_status_regs (
  input  wire        clk,
  input  wire        aresetn,
  input  wire        frame_done,
  input  wire uart_rx_pkg::frame_word_u frame_word,
  input  wire        stop_bad,
  input  wire        bit8,
  input  wire        parity_en,
  input  wire        odd_n_even,          // odd parity when set
  input  wire        read_rx_byte,
  input  wire        clear_parity,
  input  wire        clear_framing_error,
  output logic [7:0] rx_byte,
  output logic       receive_full,
  output logic       overflow,
  output logic       parity_err,
  output logic       framing_error
);

  logic [7:0] data_byte;
  logic       par_bit;
  logic       ones_odd;  // odd count of ones over data and parity
  logic       bad_par;
  logic       byte_free;

  // pick the frame view for the current format
  assign data_byte = bit8 ? frame_word.wide.data : {1'b0, frame_word.narrow.data};
  assign par_bit   = bit8 ? frame_word.wide.par  : frame_word.narrow.par;
  assign ones_odd  = ^{data_byte, par_bit};
  assign bad_par   = ones_odd ^ odd_n_even;

  // a read in the same clk makes room for the new byte
  assign byte_free = !receive_full || read_rx_byte;

  // ----------------------------------------
  // holding byte, full and overflow
  // ----------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte      <= '0;
      receive_full <= 1'b0;
      overflow     <= 1'b0;
    end
    else
    begin
      if (read_rx_byte)
      begin
        receive_full <= 1'b0;
        overflow     <= 1'b0;
      end
      if (frame_done)
      begin
        if (byte_free)
        begin
          rx_byte      <= data_byte;
          receive_full <= 1'b1;
        end
        else
        begin
          overflow <= 1'b1; // held byte is kept
        end
      end
    end
  end

  // ----------------------------------------
  // error flags, a new error beats its clear
  // ----------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      parity_err    <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (clear_parity)
        parity_err <= 1'b0;
      if (frame_done && parity_en && bad_par)
        parity_err <= 1'b1;

      if (clear_framing_error)
        framing_error <= 1'b0;
      if (stop_bad)
        framing_error <= 1'b1;
    end
  end

  a_overflow_needs_full: assert property (@(posedge clk) disable iff (!aresetn)
    overflow |-> receive_full);

endmodule

`default_nettype wire

//--- hdl/rx_frame_fsm.sv
// receive frame state machine
`timescale 1ns/1ps
`default_nettype none

module rx_frame_fsm (
  input  wire  clk,
  input  wire  aresetn,
  input  wire  rx_filtered,
  input  wire  start_seen,
  input  wire  sample_now,
  input  wire  stop_check,
  input  wire  wait_done,
  input  wire  bit8,        // 8 data bits when set, else 7
  input  wire  parity_en,
  output logic in_idle,
  output logic in_wait,
  output logic frame_done,
  output uart_rx_pkg::frame_word_u frame_word,
  output logic stop_bad     // stop bit read low
);

  uart_rx_pkg::rx_state_e state;
  uart_rx_pkg::bit_cnt_t  bit_cnt;   // bits shifted in so far
  uart_rx_pkg::bit_cnt_t  frame_len; // data bits plus parity
  logic [8:0]             shift_reg;
  logic                   all_in;

  assign all_in = (bit_cnt == frame_len);

  // ----------------------------------------
  // state and bit count
  // ----------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state     <= uart_rx_pkg::idle;
      bit_cnt   <= '0;
      frame_len <= '0;
    end
    else
    begin
      case (state)
        uart_rx_pkg::idle:
        begin
          if (start_seen)
          begin
            state     <= uart_rx_pkg::data_bits;
            bit_cnt   <= '0;
            // format is taken once per frame
            frame_len <= (bit8 ? 4'd8 : 4'd7) + {3'b000, parity_en};
          end
        end
        uart_rx_pkg::data_bits:
        begin
          if (all_in)
            state <= uart_rx_pkg::stop_bit;
          else if (sample_now)
            bit_cnt <= bit_cnt + 4'd1;
        end
        uart_rx_pkg::stop_bit:
        begin
          if (sample_now) // end of the stop bit period
            state <= uart_rx_pkg::wait_state;
        end
        uart_rx_pkg::wait_state:
        begin
          // a low line after the stop bit is not taken as a new start
          if (rx_filtered || wait_done)
            state <= uart_rx_pkg::idle;
        end
        default:
        begin
          state <= uart_rx_pkg::idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // data shift register
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (state == uart_rx_pkg::idle && start_seen)
      shift_reg <= '0; // unused top bits stay zero
    else if (state == uart_rx_pkg::data_bits && sample_now && !all_in)
      shift_reg[bit_cnt] <= rx_filtered; // lsb first, lands right-justified
  end

  assign frame_word = shift_reg;

  assign in_idle    = (state == uart_rx_pkg::idle);
  assign in_wait    = (state == uart_rx_pkg::wait_state);
  assign frame_done = (state == uart_rx_pkg::data_bits) && all_in;
  assign stop_bad   = (state == uart_rx_pkg::stop_bit) && stop_check && !rx_filtered;

  // states only ever step forward by one, wrapping from wait back to idle
  a_state_order: assert property (@(posedge clk) disable iff (!aresetn)
    $changed(state) |-> (state == 2'($past(state) + 2'd1)));

  // a frame completes on the clk right after its last bit is sampled
  a_done_after_sample: assert property (@(posedge clk) disable iff (!aresetn)
    frame_done |-> $past(sample_now));

endmodule

`default_nettype wire

//--- hdl/rx_bit_timer.sv
// receive oversample timer
`timescale 1ns/1ps
`default_nettype none

module rx_bit_timer (
  input  wire  clk,
  input  wire  aresetn,
  input  wire  baud_tick,
  input  wire  rx_filtered,
  input  wire  in_idle,     // fsm waiting for a start bit
  input  wire  in_wait,     // fsm waiting for the line to go high
  output logic start_seen,
  output logic sample_now,
  output logic stop_check,
  output logic wait_done
);

  localparam int cnt_w = $clog2(uart_rx_pkg::ticks_per_bit);

  localparam logic [cnt_w-1:0] start_pos  = cnt_w'(uart_rx_pkg::start_check_tick);
  localparam logic [cnt_w-1:0] sample_pos = cnt_w'(uart_rx_pkg::sample_tick);
  localparam logic [cnt_w-1:0] stop_pos   = cnt_w'(uart_rx_pkg::stop_check_tick);
  localparam logic [cnt_w-1:0] wait_pos   = cnt_w'(uart_rx_pkg::wait_ticks);

  logic [cnt_w-1:0] tick_cnt; // wraps once per bit period
  logic             restart;

  // held at zero while the idle line is high, realigned on a start bit
  assign restart = (in_idle && (rx_filtered || tick_cnt == start_pos)) ||
                   (in_wait && tick_cnt == wait_pos);

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      tick_cnt <= '0;
    end
    else if (baud_tick)
    begin
      if (restart)
        tick_cnt <= '0;
      else
        tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // ----------------------------------------
  // tick position decode
  // ----------------------------------------
  assign start_seen = baud_tick && in_idle && !rx_filtered && (tick_cnt == start_pos);
  assign sample_now = baud_tick && (tick_cnt == sample_pos); // late in the bit, after filter delay
  assign stop_check = baud_tick && (tick_cnt == stop_pos);
  assign wait_done  = baud_tick && in_wait && (tick_cnt == wait_pos);

  // while waiting for a start the count never gets past mid start bit
  a_idle_count_low: assert property (@(posedge clk) disable iff (!aresetn)
    in_idle |-> !(sample_now || stop_check));

endmodule

`default_nettype wire

//--- hdl/rx_majority_filter.sv
// rx line glitch filter
`timescale 1ns/1ps
`default_nettype none

module rx_majority_filter (
  input  wire  clk,
  input  wire  aresetn,
  input  wire  baud_tick,   // 16x bit rate strobe
  input  wire  rx,          // raw serial line
  output logic rx_filtered  // majority of the last three samples
);

  logic [2:0] samples; // newest sample on top

  // ----------------------------------------
  // sample window
  // ----------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples <= 3'b111; // line idles high
    end
    else if (baud_tick)
    begin
      samples <= {rx, samples[2:1]};
    end
  end

  // two out of three wins, so a one-tick glitch never gets through
  assign rx_filtered = (samples[0] & samples[1]) |
                       (samples[1] & samples[2]) |
                       (samples[0] & samples[2]);

endmodule

`default_nettype wire

//--- hdl/uart_rx_pkg.sv
// uart receiver shared definitions
`default_nettype none

package uart_rx_pkg;

  // ----------------------------------------
  // oversampling positions within a bit
  // ----------------------------------------
  localparam int unsigned ticks_per_bit    = 16; // baud_ticks per serial bit
  localparam int unsigned start_check_tick = 8;  // mid start bit
  localparam int unsigned sample_tick      = 15; // data and parity sample point
  localparam int unsigned stop_check_tick  = 14; // stop bit level check
  localparam int unsigned wait_ticks       = 6;  // give up on a stuck low line

  // number of bits shifted in, at most 8 data plus parity
  typedef logic [3:0] bit_cnt_t;

  // receive sequence, each step is +1 in the encoding
  typedef enum logic [1:0] {
    idle       = 2'd0,
    data_bits  = 2'd1,
    stop_bit   = 2'd2,
    wait_state = 2'd3
  } rx_state_e;

  // ----------------------------------------
  // received frame, lsb first, right-justified
  // ----------------------------------------
  typedef struct packed {
    logic       par;  // parity bit, or zero without parity
    logic [7:0] data;
  } frame_wide_t;

  typedef struct packed {
    logic       unused; // always zero in 7-bit mode
    logic       par;
    logic [6:0] data;
  } frame_narrow_t;

  // 8-bit frames use the wide view, 7-bit frames the narrow one
  typedef union packed {
    frame_wide_t   wide;
    frame_narrow_t narrow;
  } frame_word_u;

endpackage

`default_nettype wire
